// ==== dcache_top.f ====
source/dcache_pkg.sv
source/dcache_data_sram.sv
source/dcache_tag_array.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module dcache_tb -f dcache_top.f -o dcache_sim

status=0
./obj_dir/dcache_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
exit $status

// ==== testbench/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

  logic                  clk0;
  logic                  init;
  logic                  cpu_req_valid;
  dcache_pkg::cpu_req_t  cpu_req;
  logic                  cpu_ready;
  logic                  cpu_resp_valid;
  dcache_pkg::cpu_resp_t cpu_resp;
  logic                  mem_req_valid;
  dcache_pkg::mem_req_t  mem_req;
  logic                  mem_resp_valid;
  dcache_pkg::line_t     mem_rdata;

  integer               seed = 32'hd29b;
  int                   cycle_count = 0;
  int                   mem_req_count = 0;
  dcache_pkg::mem_req_t last_mem_req;

  // Backing memory keyed by line address
  dcache_pkg::line_t mem_lines [dcache_pkg::addr_t];

  // Shadow of the tag store for hit prediction
  dcache_pkg::tag_t shadow_tag [dcache_pkg::line_count];
  logic             shadow_valid [dcache_pkg::line_count];

  dcache_top dcache_top_i (
    .clk0, .init,
    .cpu_req_valid, .cpu_req, .cpu_ready, .cpu_resp_valid, .cpu_resp,
    .mem_req_valid, .mem_req, .mem_resp_valid, .mem_rdata
  );

  initial begin
    clk0 = 1'b0;
    forever #50 clk0 = ~clk0;
  end

  // About 20 accesses of at most 12 cycles each plus resets stay well below this
  always @(posedge clk0) begin
    cycle_count++;
    if (cycle_count >= 2000) begin
      $display("Timeout: the run hung after %0d cycles", cycle_count);
      $display("test failed");
      $fatal(1);
    end
  end

  function automatic dcache_pkg::line_t mem_line(input dcache_pkg::addr_t line_addr);
    dcache_pkg::line_t pattern;
    if (mem_lines.exists(line_addr)) return mem_lines[line_addr];
    for (int w = 0; w < 4; w++) begin
      pattern[w*32 +: 32] = (line_addr + 32'(w * 4)) * 32'h9e37_79b1 ^ 32'h5a3c_0f96;
    end
    return pattern;
  endfunction

  function automatic dcache_pkg::word_t word_at(input dcache_pkg::addr_t addr);
    dcache_pkg::line_t l;
    l = mem_line({addr[31:4], 4'h0});
    return l[addr[3:2]*32 +: 32];
  endfunction

  // Memory side responder with a random delay of 1 to 4 cycles
  initial begin : memory_model
    dcache_pkg::mem_req_t req;
    dcache_pkg::line_t    line;
    int                   delay;
    mem_resp_valid = 1'b0;
    mem_rdata      = '0;
    forever begin
      @(negedge clk0);
      if (mem_req_valid) begin
        req          = mem_req;
        last_mem_req = req;
        mem_req_count++;
        if (req.write) begin
          line = mem_line({req.addr[31:4], 4'h0});
          for (int b = 0; b < 4; b++) begin
            if (req.wmask[b]) line[req.addr[3:2]*32 + b*8 +: 8] = req.wdata[b*8 +: 8];
          end
          mem_lines[{req.addr[31:4], 4'h0}] = line;
        end
        delay = 1 + ($random(seed) & 3);
        repeat (delay) @(posedge clk0);
        #1;
        mem_resp_valid = 1'b1;
        mem_rdata      = req.write ? '0 : mem_line(req.addr);
        @(posedge clk0);
        #1;
        mem_resp_valid = 1'b0;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk0);
    #1;
    init = 1'b1;
    repeat (4) @(posedge clk0);
    #1;
    init = 1'b0;
    for (int i = 0; i < dcache_pkg::line_count; i++) shadow_valid[i] = 1'b0;
  endtask

  // One CPU access with its latency in falling edges from acceptance to the response
  task automatic cpu_access(input logic write, input dcache_pkg::addr_t addr,
                            input dcache_pkg::word_t wdata, input dcache_pkg::word_mask_t wmask,
                            output dcache_pkg::cpu_resp_t resp, output int latency);
    @(posedge clk0);
    #1;
    cpu_req_valid = 1'b1;
    cpu_req       = '{write, addr, wdata, wmask};
    @(negedge clk0);
    while (!cpu_ready) @(negedge clk0);
    @(posedge clk0);
    #1;
    cpu_req_valid = 1'b0;
    latency       = 0;
    do begin
      @(negedge clk0);
      latency++;
      check_value("cpu_ready", 32'(cpu_ready), 0);
    end while (!cpu_resp_valid);
    resp = cpu_resp;
  endtask

  task automatic load_check(input dcache_pkg::addr_t addr);
    dcache_pkg::cpu_resp_t resp;
    dcache_pkg::index_t    idx;
    logic                  exp_hit;
    int                    reqs_before;
    int                    latency;
    idx         = addr[9:4];
    exp_hit     = shadow_valid[idx] && (shadow_tag[idx] == addr[31:10]);
    reqs_before = mem_req_count;
    cpu_access(1'b0, addr, '0, '0, resp, latency);
    check_value("cpu_resp.hit", 32'(resp.hit), 32'(exp_hit));
    check_value("cpu_resp.rdata", resp.rdata, word_at(addr));
    if (exp_hit) begin
      check_value("mem_req count", mem_req_count - reqs_before, 0);
      check_value("hit latency", latency, 2);
    end else begin
      check_value("mem_req count", mem_req_count - reqs_before, 1);
      check_value("mem_req.write", 32'(last_mem_req.write), 0);
      check_value("mem_req.addr", last_mem_req.addr, {addr[31:4], 4'h0});
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = addr[31:10];
    end
  endtask

  // Stores never allocate, so the shadow stays as it is
  task automatic store_check(input dcache_pkg::addr_t addr, input dcache_pkg::word_t wdata,
                             input dcache_pkg::word_mask_t wmask);
    dcache_pkg::cpu_resp_t resp;
    dcache_pkg::index_t    idx;
    logic                  exp_hit;
    int                    reqs_before;
    int                    latency;
    idx         = addr[9:4];
    exp_hit     = shadow_valid[idx] && (shadow_tag[idx] == addr[31:10]);
    reqs_before = mem_req_count;
    cpu_access(1'b1, addr, wdata, wmask, resp, latency);
    check_value("cpu_resp.hit", 32'(resp.hit), 32'(exp_hit));
    check_value("mem_req count", mem_req_count - reqs_before, 1);
    check_value("mem_req.write", 32'(last_mem_req.write), 1);
    check_value("mem_req.addr", last_mem_req.addr, {addr[31:2], 2'b00});
    check_value("mem_req.wdata", last_mem_req.wdata, wdata);
    check_value("mem_req.wmask", 32'(last_mem_req.wmask), 32'(wmask));
  endtask

  task automatic reset_defaults();
    check_value("cpu_ready", 32'(cpu_ready), 1);
    repeat (3) begin
      @(negedge clk0);
      check_value("cpu_resp_valid", 32'(cpu_resp_valid), 0);
      check_value("mem_req_valid", 32'(mem_req_valid), 0);
    end
    load_check(32'h0000_1234);
  endtask

  task automatic same_line_hits();
    load_check(32'h0000_1230);
    load_check(32'h0000_123c);
  endtask

  task automatic store_hit_merge();
    store_check(32'h0000_1238, 32'hdead_beef, 4'b0110);
    load_check(32'h0000_1238);
  endtask

  task automatic store_miss_no_allocate();
    store_check(32'h0004_5674, 32'h1357_9bdf, 4'b1111);
    load_check(32'h0004_5674);
  endtask

  // Two tags on one index evict each other
  task automatic index_eviction();
    dcache_pkg::index_t idx;
    dcache_pkg::addr_t  addr_a;
    dcache_pkg::addr_t  addr_b;
    idx    = dcache_pkg::index_t'($random(seed));
    addr_a = {22'h01_2345, idx, 4'h4};
    addr_b = {22'h2a_bcde, idx, 4'h8};
    mem_lines[{addr_a[31:4], 4'h0}] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    mem_lines[{addr_b[31:4], 4'h0}] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    repeat (2) begin
      load_check(addr_a);
      load_check(addr_b);
    end
  endtask

  task automatic init_invalidates();
    load_check(32'h0000_1230);
    load_check(32'h0000_1230);
    apply_reset();
    load_check(32'h0000_1230);
  endtask

  initial begin
    init          = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    apply_reset();
    reset_defaults();
    same_line_hits();
    store_hit_merge();
    store_miss_no_allocate();
    index_eviction();
    init_invalidates();
    $display("test passed");
    $finish;
  end

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top (
  input  logic                  clk0,
  input  logic                  init,
  input  logic                  cpu_req_valid,
  input  dcache_pkg::cpu_req_t  cpu_req,
  output logic                  cpu_ready,
  output logic                  cpu_resp_valid,
  output dcache_pkg::cpu_resp_t cpu_resp,
  output logic                  mem_req_valid,
  output dcache_pkg::mem_req_t  mem_req,
  input  logic                  mem_resp_valid,
  input  dcache_pkg::line_t     mem_rdata
);

  logic                   sram_csb;
  logic                   sram_web;
  dcache_pkg::index_t     sram_addr;
  dcache_pkg::line_mask_t sram_wmask;
  dcache_pkg::line_t      sram_din;
  dcache_pkg::line_t      sram_dout;
  logic                   tag_cs;
  logic                   tag_we;
  dcache_pkg::index_t     tag_index;
  dcache_pkg::tag_t       tag_din;
  dcache_pkg::tag_t       tag_dout;
  logic                   tag_valid;

  dcache_ctrl ctrl_i (
    .clk0, .init,
    .cpu_req_valid, .cpu_req, .cpu_ready, .cpu_resp_valid, .cpu_resp,
    .mem_req_valid, .mem_req, .mem_resp_valid, .mem_rdata,
    .sram_csb, .sram_web, .sram_addr, .sram_wmask, .sram_din, .sram_dout,
    .tag_cs, .tag_we, .tag_index, .tag_din, .tag_dout, .tag_valid
  );

  dcache_data_sram data_sram_i (
    .clk0  (clk0),
    .init  (init),
    .csb   (sram_csb),
    .web   (sram_web),
    .addr  (sram_addr),
    .wmask (sram_wmask),
    .din   (sram_din),
    .dout  (sram_dout)
  );

  dcache_tag_array tag_array_i (
    .clk0  (clk0),
    .init  (init),
    .cs    (tag_cs),
    .we    (tag_we),
    .index (tag_index),
    .din   (tag_din),
    .dout  (tag_dout),
    .valid (tag_valid)
  );

endmodule

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl (
  input  logic                   clk0,
  input  logic                   init,
  input  logic                   cpu_req_valid,
  input  dcache_pkg::cpu_req_t   cpu_req,
  output logic                   cpu_ready,
  output logic                   cpu_resp_valid,
  output dcache_pkg::cpu_resp_t  cpu_resp,
  output logic                   mem_req_valid,
  output dcache_pkg::mem_req_t   mem_req,
  input  logic                   mem_resp_valid,
  input  dcache_pkg::line_t      mem_rdata,
  output logic                   sram_csb,
  output logic                   sram_web,
  output dcache_pkg::index_t     sram_addr,
  output dcache_pkg::line_mask_t sram_wmask,
  output dcache_pkg::line_t      sram_din,
  input  dcache_pkg::line_t      sram_dout,
  output logic                   tag_cs,
  output logic                   tag_we,
  output dcache_pkg::index_t     tag_index,
  output dcache_pkg::tag_t       tag_din,
  input  dcache_pkg::tag_t       tag_dout,
  input  logic                   tag_valid
);

  dcache_pkg::ctrl_state_t state;
  dcache_pkg::ctrl_state_t state_next;
  dcache_pkg::cpu_req_t    req_q;
  dcache_pkg::line_t       line_q;
  dcache_pkg::word_t       rdata_q;
  logic                    hit_q;

  dcache_pkg::index_t      req_index;
  dcache_pkg::tag_t        req_tag;
  dcache_pkg::word_sel_t   req_word;
  logic                    hit;

  assign req_index = req_q.addr[9:4];
  assign req_tag   = req_q.addr[31:10];
  assign req_word  = req_q.addr[3:2];

  // Stored tag compare used in lookup
  assign hit = tag_valid && (tag_dout == req_tag);

  always_comb begin
    state_next = state;
    case (state)
      dcache_pkg::idle:      if (cpu_req_valid) state_next = dcache_pkg::lookup;
      dcache_pkg::lookup: begin
        if (req_q.write) begin
          state_next = dcache_pkg::wt_req;
        end else if (hit) begin
          state_next = dcache_pkg::respond;
        end else begin
          state_next = dcache_pkg::miss_req;
        end
      end
      dcache_pkg::miss_req:  state_next = dcache_pkg::miss_wait;
      dcache_pkg::miss_wait: if (mem_resp_valid) state_next = dcache_pkg::fill;
      dcache_pkg::fill:      state_next = dcache_pkg::respond;
      dcache_pkg::wt_req:    state_next = dcache_pkg::wt_wait;
      dcache_pkg::wt_wait:   if (mem_resp_valid) state_next = dcache_pkg::respond;
      default:               state_next = dcache_pkg::idle;
    endcase
  end

  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      state <= dcache_pkg::idle;
      hit_q <= 1'b0;
    end else begin
      state <= state_next;
      if (state == dcache_pkg::lookup) begin
        hit_q <= hit;
      end
    end
  end

  // Request, fill line and load data
  always_ff @(posedge clk0) begin
    if (state == dcache_pkg::idle && cpu_req_valid) begin
      req_q <= cpu_req;
    end
    if (state == dcache_pkg::miss_wait && mem_resp_valid) begin
      line_q <= mem_rdata;
    end
    if (state == dcache_pkg::lookup) begin
      rdata_q <= sram_dout[req_word*32 +: 32];
    end else if (state == dcache_pkg::fill) begin
      rdata_q <= line_q[req_word*32 +: 32];
    end
  end

  // Array ports
  always_comb begin
    sram_csb   = 1'b1;
    sram_web   = 1'b1;
    sram_addr  = req_index;
    sram_wmask = dcache_pkg::line_mask_t'(req_q.wmask) << (req_word * 4);
    sram_din   = {4{req_q.wdata}};
    tag_cs     = 1'b0;
    tag_we     = 1'b0;
    tag_index  = req_index;
    case (state)
      dcache_pkg::idle: begin
        // Start both reads as the request is taken
        sram_csb  = !cpu_req_valid;
        sram_addr = cpu_req.addr[9:4];
        tag_cs    = cpu_req_valid;
        tag_index = cpu_req.addr[9:4];
      end
      dcache_pkg::lookup: begin
        if (req_q.write && hit) begin
          sram_csb = 1'b0;
          sram_web = 1'b0;
        end
      end
      dcache_pkg::fill: begin
        sram_csb   = 1'b0;
        sram_web   = 1'b0;
        sram_wmask = '1;
        sram_din   = line_q;
        tag_cs     = 1'b1;
        tag_we     = 1'b1;
      end
      default: ;
    endcase
  end

  assign tag_din = req_tag;

  assign cpu_ready      = (state == dcache_pkg::idle);
  assign cpu_resp_valid = (state == dcache_pkg::respond);
  assign cpu_resp.rdata = rdata_q;
  assign cpu_resp.hit   = hit_q;

  assign mem_req_valid = (state == dcache_pkg::miss_req) || (state == dcache_pkg::wt_req);
  assign mem_req.write = req_q.write;
  // Line address for fills, word address for write-through
  assign mem_req.addr  = req_q.write ? {req_q.addr[31:2], 2'b00} : {req_q.addr[31:4], 4'h0};
  assign mem_req.wdata = req_q.wdata;
  assign mem_req.wmask = req_q.wmask;

endmodule

// ==== source/dcache_tag_array.sv ====
`timescale 1ns/100ps

module dcache_tag_array (
  input  logic               clk0,
  input  logic               init,
  input  logic               cs,
  input  logic               we,
  input  dcache_pkg::index_t index,
  input  dcache_pkg::tag_t   din,
  output dcache_pkg::tag_t   dout,
  output logic               valid
);

  logic               cs_q;
  logic               we_q;
  dcache_pkg::index_t index_q;
  dcache_pkg::tag_t   din_q;

  dcache_pkg::tag_t               tags [dcache_pkg::line_count];
  logic [dcache_pkg::line_count-1:0] valid_bits;

  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      cs_q    <= 1'b0;
      we_q    <= 1'b0;
      index_q <= '0;
      din_q   <= '0;
    end else begin
      cs_q    <= cs;
      we_q    <= we;
      index_q <= index;
      din_q   <= din;
    end
  end

  // Tag storage written on the falling edge
  always_ff @(negedge clk0) begin
    if (cs_q && we_q) begin
      tags[index_q] <= din_q;
    end
  end

  always_ff @(negedge clk0 or posedge init) begin
    if (init) begin
      valid_bits <= '0;
      dout       <= '0;
      valid      <= 1'b0;
    end else if (cs_q) begin
      if (we_q) begin
        valid_bits[index_q] <= 1'b1;
      end else begin
        dout  <= tags[index_q];
        valid <= valid_bits[index_q];
      end
    end
  end

endmodule

// ==== source/dcache_data_sram.sv ====
`timescale 1ns/100ps

module dcache_data_sram (
  input  logic                   clk0,
  input  logic                   init,
  input  logic                   csb,
  input  logic                   web,
  input  dcache_pkg::index_t     addr,
  input  dcache_pkg::line_mask_t wmask,
  input  dcache_pkg::line_t      din,
  output dcache_pkg::line_t      dout
);

  logic                   csb_q;
  logic                   web_q;
  dcache_pkg::index_t     addr_q;
  dcache_pkg::line_mask_t wmask_q;
  dcache_pkg::line_t      din_q;

  dcache_pkg::line_t mem [dcache_pkg::line_count];

  // Port inputs captured on the rising edge
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      csb_q   <= 1'b1;
      web_q   <= 1'b1;
      addr_q  <= '0;
      wmask_q <= '0;
      din_q   <= '0;
    end else begin
      csb_q   <= csb;
      web_q   <= web;
      addr_q  <= addr;
      wmask_q <= wmask;
      din_q   <= din;
    end
  end

  // Array access on the falling edge with dout held until the next read
  always_ff @(negedge clk0 or posedge init) begin
    if (init) begin
      dout <= '0;
      for (int i = 0; i < dcache_pkg::line_count; i++) begin
        mem[i] <= '0;
      end
    end else if (!csb_q) begin
      if (!web_q) begin
        // Byte lanes gated by the registered mask
        for (int b = 0; b < dcache_pkg::line_bytes; b++) begin
          if (wmask_q[b]) begin
            mem[addr_q][b*8 +: 8] <= din_q[b*8 +: 8];
          end
        end
      end else begin
        dout <= mem[addr_q];
      end
    end
  end

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

  // Cache geometry
  localparam int line_count = 64;
  localparam int line_bytes = 16;

  typedef logic [31:0] addr_t;
  typedef logic [$clog2(line_count)-1:0] index_t;
  typedef logic [21:0] tag_t;
  typedef logic [1:0] word_sel_t;
  typedef logic [31:0] word_t;
  typedef logic [line_bytes*8-1:0] line_t;
  typedef logic [3:0] word_mask_t;
  typedef logic [line_bytes-1:0] line_mask_t;

  typedef struct packed {
    logic       write;
    addr_t      addr;
    word_t      wdata;
    word_mask_t wmask;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;
    logic  hit;
  } cpu_resp_t;

  // Line reads carry the aligned address, word writes the word address
  typedef struct packed {
    logic       write;
    addr_t      addr;
    word_t      wdata;
    word_mask_t wmask;
  } mem_req_t;

  typedef enum logic [2:0] {
    idle, lookup, miss_req, miss_wait, fill, wt_req, wt_wait, respond
  } ctrl_state_t;

endpackage
